// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_execute
FILELIST  ?= sources.f
GOLDEN    ?= mips_execute_golden.hex
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(GOLDEN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mips_alu.sv
`timescale 1ns/1ps

module mips_alu import mips_alu_pkg::*; (
  input  instr_fields_t fields,
  input  logic          issue,
  input  word_t         rs_content,
  input  word_t         rt_content,
  input  word_t         hi,
  input  word_t         lo,
  output word_t         alu_result,
  output logic          branch_taken,
  output logic          md_start,
  output muldiv_req_t   md_req
);

  imm_t  imm;
  word_t sign_ext;
  word_t zero_ext;
  logic  is_muldiv;

  assign imm      = {fields.rd, fields.shamt, fields.funct};
  assign sign_ext = {{16{imm[15]}}, imm};
  assign zero_ext = {16'h0000, imm};

  assign is_muldiv = (fields.opcode == OP_SPECIAL) &&
                     (fields.funct == F_MULT || fields.funct == F_MULTU ||
                      fields.funct == F_DIV  || fields.funct == F_DIVU);

  assign md_start         = issue && is_muldiv;
  assign md_req.is_div    = fields.funct[1];  // DIV/DIVU
  assign md_req.is_signed = ~fields.funct[0]; // MULT/DIV
  assign md_req.a         = rs_content;
  assign md_req.b         = rt_content;

  always_comb
  begin
    alu_result   = '0;
    branch_taken = 1'b0;
    case (fields.opcode)
      OP_SPECIAL:
      begin
        case (fields.funct)
          F_ADDU:  alu_result = rs_content + rt_content;
          F_SUBU:  alu_result = rs_content - rt_content;
          F_AND:   alu_result = rs_content & rt_content;
          F_OR:    alu_result = rs_content | rt_content;
          F_XOR:   alu_result = rs_content ^ rt_content;
          F_SLL:   alu_result = rt_content << fields.shamt;
          F_SRL:   alu_result = rt_content >> fields.shamt;
          F_SRA:   alu_result = word_t'($signed(rt_content) >>> fields.shamt);
          F_SLLV:  alu_result = rt_content << rs_content[4:0]; // Low five bits only
          F_SRLV:  alu_result = rt_content >> rs_content[4:0];
          F_SRAV:  alu_result = word_t'($signed(rt_content) >>> rs_content[4:0]);
          F_SLT:   alu_result = word_t'($signed(rs_content) < $signed(rt_content));
          F_SLTU:  alu_result = word_t'(rs_content < rt_content);
          F_MFHI:  alu_result = hi;
          F_MFLO:  alu_result = lo;
          default: alu_result = '0; // MULT/DIV results land in HI/LO
        endcase
      end

      OP_ADDIU: alu_result = rs_content + sign_ext;
      OP_ANDI:  alu_result = rs_content & zero_ext;
      OP_ORI:   alu_result = rs_content | zero_ext;
      OP_XORI:  alu_result = rs_content ^ zero_ext;
      OP_LUI:   alu_result = {imm, 16'h0000};
      OP_SLTI:  alu_result = word_t'($signed(rs_content) < $signed(sign_ext));
      OP_SLTIU: alu_result = word_t'(rs_content < sign_ext); // Unsigned compare, extended imm

      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW:
        alu_result = rs_content + sign_ext; // Effective address

      OP_BEQ: branch_taken = (rs_content == rt_content);
      OP_BNE: branch_taken = (rs_content != rt_content);

      OP_REGIMM:
      begin
        case (fields.rt)
          5'h00, 5'h10: branch_taken = $signed(rs_content) < 0;  // BLTZ, BLTZAL
          5'h01, 5'h11: branch_taken = $signed(rs_content) >= 0; // BGEZ, BGEZAL
          default:      branch_taken = 1'b0;
        endcase
      end

      OP_BGTZ:
        branch_taken = (fields.rt == '0) && ($signed(rs_content) > 0);
      OP_BLEZ:
        branch_taken = (fields.rt == '0) && ($signed(rs_content) <= 0);

      default:
      begin
        alu_result   = '0;
        branch_taken = 1'b0;
      end
    endcase
  end

endmodule

// File: mips_alu_pkg.sv
package mips_alu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [63:0] dword_t; // HI:LO pair
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [15:0] imm_t;

  // R-type layout; the I-type immediate is {rd, shamt, funct}
  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    shamt_t   shamt;
    funct_t   funct;
  } instr_fields_t;

  localparam opcode_t OP_SPECIAL = 6'h00;
  localparam opcode_t OP_REGIMM  = 6'h01;
  localparam opcode_t OP_BEQ     = 6'h04;
  localparam opcode_t OP_BNE     = 6'h05;
  localparam opcode_t OP_BLEZ    = 6'h06;
  localparam opcode_t OP_BGTZ    = 6'h07;
  localparam opcode_t OP_ADDIU   = 6'h09;
  localparam opcode_t OP_SLTI    = 6'h0a;
  localparam opcode_t OP_SLTIU   = 6'h0b;
  localparam opcode_t OP_ANDI    = 6'h0c;
  localparam opcode_t OP_ORI     = 6'h0d;
  localparam opcode_t OP_XORI    = 6'h0e;
  localparam opcode_t OP_LUI     = 6'h0f;
  localparam opcode_t OP_LB      = 6'h20;
  localparam opcode_t OP_LH      = 6'h21;
  localparam opcode_t OP_LW      = 6'h23;
  localparam opcode_t OP_LBU     = 6'h24;
  localparam opcode_t OP_LHU     = 6'h25;
  localparam opcode_t OP_SB      = 6'h28;
  localparam opcode_t OP_SH      = 6'h29;
  localparam opcode_t OP_SW      = 6'h2b;

  localparam funct_t F_SLL   = 6'h00;
  localparam funct_t F_SRL   = 6'h02;
  localparam funct_t F_SRA   = 6'h03;
  localparam funct_t F_SLLV  = 6'h04;
  localparam funct_t F_SRLV  = 6'h06;
  localparam funct_t F_SRAV  = 6'h07;
  localparam funct_t F_MFHI  = 6'h10;
  localparam funct_t F_MFLO  = 6'h12;
  localparam funct_t F_MULT  = 6'h18;
  localparam funct_t F_MULTU = 6'h19;
  localparam funct_t F_DIV   = 6'h1a;
  localparam funct_t F_DIVU  = 6'h1b;
  localparam funct_t F_ADDU  = 6'h21;
  localparam funct_t F_SUBU  = 6'h23;
  localparam funct_t F_AND   = 6'h24;
  localparam funct_t F_OR    = 6'h25;
  localparam funct_t F_XOR   = 6'h26;
  localparam funct_t F_SLT   = 6'h2a;
  localparam funct_t F_SLTU  = 6'h2b;

  localparam int MULDIV_ITERS = $bits(word_t); // One bit per iteration

  typedef enum logic [1:0] {
    MD_IDLE,
    MD_RUN,
    MD_FIX
  } muldiv_state_t;

  typedef struct packed {
    logic  is_div;
    logic  is_signed;
    word_t a; // rs
    word_t b; // rt
  } muldiv_req_t;

endpackage

// File: mips_execute.sv
`timescale 1ns/1ps

module mips_execute import mips_alu_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  word_t instr,
  input  word_t rs_content,
  input  word_t rt_content,
  input  logic  issue,
  output word_t alu_result,
  output logic  branch_taken,
  output word_t hi,
  output word_t lo,
  output logic  busy
);

  instr_fields_t fields;
  muldiv_req_t   md_req;
  logic          md_start;
  logic          load_ops;
  logic          step;
  logic          commit;
  logic          last;

  assign fields = instr_fields_t'(instr);

  mips_alu u_alu (
    .fields       (fields),
    .issue        (issue),
    .rs_content   (rs_content),
    .rt_content   (rt_content),
    .hi           (hi),
    .lo           (lo),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .md_start     (md_start),
    .md_req       (md_req)
  );

  muldiv_ctrl u_ctrl (
    .clk      (clk),
    .arst_n   (arst_n),
    .md_start (md_start),
    .last     (last),
    .busy     (busy),
    .load_ops (load_ops),
    .step     (step),
    .commit   (commit)
  );

  muldiv_counter u_counter (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (load_ops), // Same edge as operand capture
    .step   (step),
    .last   (last)
  );

  muldiv_datapath u_datapath (
    .clk      (clk),
    .arst_n   (arst_n),
    .load_ops (load_ops),
    .md_req   (md_req),
    .step     (step),
    .commit   (commit),
    .hi       (hi),
    .lo       (lo)
  );

endmodule

// File: mips_execute_golden.hex
// kind instr rs rt alu_result branch_taken hi lo name_index
// kind 0 ALU, 1 mul/div, 2 mul/div with a second issue while busy
0 00221821 7fffffff 00000001 80000000 0 00000000 00000000 01
0 00221823 00000005 00000007 fffffffe 0 00000000 00000000 02
0 00221824 f0f0ff00 0ff0f0f0 00f0f000 0 00000000 00000000 03
0 00221825 f0f0ff00 0ff0f0f0 fff0fff0 0 00000000 00000000 03
0 00221826 f0f0ff00 0ff0f0f0 ff000ff0 0 00000000 00000000 03
0 00221900 00000000 8000000f 000000f0 0 00000000 00000000 04
0 00221902 00000000 8000000f 08000000 0 00000000 00000000 04
0 00221903 00000000 8000000f f8000000 0 00000000 00000000 04
0 00221fc3 00000000 80000000 ffffffff 0 00000000 00000000 04
0 00221804 00000024 00000001 00000010 0 00000000 00000000 05
0 00221806 00000008 ff000000 00ff0000 0 00000000 00000000 05
0 00221807 00000010 80000000 ffff8000 0 00000000 00000000 05
0 0022182a ffffffff 00000001 00000001 0 00000000 00000000 06
0 0022182b ffffffff 00000001 00000000 0 00000000 00000000 06
0 2422ffff 00000010 00000000 0000000f 0 00000000 00000000 07
0 3022ff0f abcd1234 00000000 00001204 0 00000000 00000000 08
0 3422ff0f abcd1234 00000000 abcdff3f 0 00000000 00000000 08
0 3822ff0f abcd1234 00000000 abcded3b 0 00000000 00000000 08
0 3c22beef 00000000 00000000 beef0000 0 00000000 00000000 09
0 2822fff0 ffffffe0 00000000 00000001 0 00000000 00000000 0a
0 2c22fff0 00000005 00000000 00000001 0 00000000 00000000 0a
0 2c22fff0 fffffff8 00000000 00000000 0 00000000 00000000 0a
0 8c22fffc 00001000 00000000 00000ffc 0 00000000 00000000 0b
0 ac220010 00001000 00000000 00001010 0 00000000 00000000 0b
0 90228000 00010000 00000000 00008000 0 00000000 00000000 0b
0 10220004 00000007 00000007 00000000 1 00000000 00000000 0c
0 10220004 00000007 00000008 00000000 0 00000000 00000000 0c
0 14220004 00000007 00000008 00000000 1 00000000 00000000 0c
0 18200004 00000000 00000000 00000000 1 00000000 00000000 0d
0 18200004 00000001 00000000 00000000 0 00000000 00000000 0d
0 18220004 00000000 00000000 00000000 0 00000000 00000000 0d
0 1c200004 00000005 00000000 00000000 1 00000000 00000000 0d
0 04200004 ffffffff 00000000 00000000 1 00000000 00000000 0e
0 04210004 ffffffff 00000000 00000000 0 00000000 00000000 0e
0 04210004 00000000 00000000 00000000 1 00000000 00000000 0e
0 04300004 80000000 00000000 00000000 1 00000000 00000000 0e
0 04310004 00000003 00000000 00000000 1 00000000 00000000 0e
0 04220004 00000000 00000000 00000000 0 00000000 00000000 0e
1 00220018 fffffffd 00000007 00000000 0 ffffffff ffffffeb 0f
1 00220018 80000000 80000000 00000000 0 40000000 00000000 0f
1 00220019 ffffffff ffffffff 00000000 0 fffffffe 00000001 0f
1 0022001a fffffff9 00000002 00000000 0 ffffffff fffffffd 10
1 0022001a 00000007 fffffffe 00000000 0 00000001 fffffffd 10
1 0022001a ffffff9c fffffff9 00000000 0 fffffffe 0000000e 10
1 0022001b ffffffff 00000010 00000000 0 0000000f 0fffffff 10
1 0022001b 12345678 00000000 00000000 0 12345678 ffffffff 11
2 00220019 00000003 00000005 00000000 0 00000000 0000000f 12

// File: mips_execute_properties.sv
`timescale 1ns/1ps

module mips_execute_properties import mips_alu_pkg::*; (
  input logic  clk,
  input logic  arst_n,
  input logic  load_ops,
  input logic  busy,
  input word_t hi,
  input word_t lo
);

  // Fall lands on the 33rd edge, seen by the sampling one edge later
  a_busy_latency: assert property (@(posedge clk) disable iff (!arst_n)
    load_ops |=> busy [*33] ##1 !busy)
    else $error("busy did not fall 33 cycles after an accepted start");

  a_hilo_stable: assert property (@(posedge clk) disable iff (!arst_n)
    !$past(busy) |-> ($stable(hi) && $stable(lo)))
    else $error("hi or lo changed outside a commit");

  a_reset_idle: assert property (@(posedge clk)
    !arst_n |-> !busy)
    else $error("busy high during reset");

endmodule

bind mips_execute mips_execute_properties u_properties (
  .clk      (clk),
  .arst_n   (arst_n),
  .load_ops (load_ops),
  .busy     (busy),
  .hi       (hi),
  .lo       (lo)
);

// File: muldiv_counter.sv
`timescale 1ns/1ps

module muldiv_counter import mips_alu_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  input  logic load,
  input  logic step,
  output logic last
);

  localparam int CNT_W = $clog2(MULDIV_ITERS);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count <= '0;
    end
    else if (load)
    begin
      count <= CNT_W'(MULDIV_ITERS - 1);
    end
    else if (step && !last)
    begin
      count <= count - 1'b1; // Holds at zero after the final step
    end
  end

  assign last = (count == '0);

endmodule

// File: muldiv_ctrl.sv
`timescale 1ns/1ps

module muldiv_ctrl import mips_alu_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  input  logic md_start,
  input  logic last,
  output logic busy,
  output logic load_ops,
  output logic step,
  output logic commit
);

  muldiv_state_t state;
  muldiv_state_t state_nxt;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= MD_IDLE;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      MD_IDLE:
      begin
        if (md_start)
        begin
          state_nxt = MD_RUN;
        end
      end
      MD_RUN:
      begin
        if (last)
        begin
          state_nxt = MD_FIX; // Final step taken this cycle
        end
      end
      MD_FIX:  state_nxt = MD_IDLE;
      default: state_nxt = MD_IDLE;
    endcase
  end

  assign load_ops = (state == MD_IDLE) && md_start; // Starts while busy fall through here
  assign step     = (state == MD_RUN);
  assign commit   = (state == MD_FIX);
  assign busy     = (state != MD_IDLE);

endmodule

// File: muldiv_datapath.sv
`timescale 1ns/1ps

module muldiv_datapath import mips_alu_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        load_ops,
  input  muldiv_req_t md_req,
  input  logic        step,
  input  logic        commit,
  output word_t       hi,
  output word_t       lo
);

  dword_t acc;     // Partial product, or remainder:quotient
  word_t  op_b;    // Multiplicand or divisor magnitude
  logic   is_div;
  logic   neg_lo;  // Product or quotient negative
  logic   neg_hi;  // Remainder takes dividend sign
  word_t  mag_a;
  word_t  mag_b;
  logic [$bits(word_t):0]   mul_sum;
  logic [$bits(word_t)+1:0] div_trial;
  dword_t prod_fix;
  word_t  quot_fix;
  word_t  rem_fix;

  function automatic word_t magnitude(input word_t x, input logic is_signed);
    return (is_signed && x[31]) ? -x : x;
  endfunction

  assign mag_a = magnitude(md_req.a, md_req.is_signed);
  assign mag_b = magnitude(md_req.b, md_req.is_signed);

  // One multiplier bit per step, LSB first
  assign mul_sum = {1'b0, acc[63:32]} + {1'b0, (acc[0] ? op_b : '0)};

  // Shifted remainder minus divisor; bit 33 set means restore
  assign div_trial = {1'b0, acc[63:31]} - {2'b00, op_b};

  always_ff @(posedge clk)
  begin
    if (load_ops)
    begin
      acc    <= {32'h0000_0000, mag_a};
      op_b   <= mag_b;
      is_div <= md_req.is_div;
      neg_lo <= md_req.is_signed && (md_req.a[31] ^ md_req.b[31]);
      neg_hi <= md_req.is_signed && md_req.a[31];
    end
    else if (step)
    begin
      if (is_div)
      begin
        if (!div_trial[$bits(word_t)+1])
        begin
          acc <= {div_trial[31:0], acc[30:0], 1'b1};
        end
        else
        begin
          acc <= {acc[62:0], 1'b0};
        end
      end
      else
      begin
        acc <= {mul_sum, acc[31:1]};
      end
    end
  end

  assign prod_fix = neg_lo ? -acc : acc;
  assign quot_fix = neg_lo ? -acc[31:0] : acc[31:0];   // Truncates toward zero
  assign rem_fix  = neg_hi ? -acc[63:32] : acc[63:32];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hi <= '0;
      lo <= '0;
    end
    else if (commit)
    begin
      if (is_div)
      begin
        hi <= rem_fix;
        lo <= quot_fix;
      end
      else
      begin
        hi <= prod_fix[63:32];
        lo <= prod_fix[31:0];
      end
    end
  end

endmodule

// File: sources.f
mips_alu_pkg.sv
mips_alu.sv
muldiv_ctrl.sv
muldiv_counter.sv
muldiv_datapath.sv
mips_execute.sv
mips_execute_properties.sv
tb_mips_execute.sv

// File: tb_mips_execute.sv
`timescale 1ns/1ps

module tb_mips_execute;

  localparam int COLS     = 9;  // Words per golden line
  localparam int NUM_VECS = 47;
  localparam int MAX_WAIT = 40; // Cycles allowed for busy to fall
  localparam logic [31:0] MFHI_INSTR = 32'h0000_1810;
  localparam logic [31:0] MFLO_INSTR = 32'h0000_1812;

  logic        clk;
  logic        arst_n;
  logic [31:0] instr;
  logic [31:0] rs_content;
  logic [31:0] rt_content;
  logic        issue;
  logic [31:0] alu_result;
  logic        branch_taken;
  logic [31:0] hi;
  logic [31:0] lo;
  logic        busy;

  logic [31:0] golden [0:511];
  string       names [0:18];

  mips_execute u_mips_execute (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr        (instr),
    .rs_content   (rs_content),
    .rt_content   (rt_content),
    .issue        (issue),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .hi           (hi),
    .lo           (lo),
    .busy         (busy)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] vec_field(input int v, input int k);
    return golden[9'(v * COLS + k)];
  endfunction

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR %s: expected %h, actual %h", test, expected, actual);
      $display("Checks failed");
      $fatal(1, "Mismatch in %s", test);
    end
  endtask

  task automatic apply(input logic [31:0] i, input logic [31:0] rs, input logic [31:0] rt,
                       input logic iss);
    @(negedge clk);
    instr      = i;
    rs_content = rs;
    rt_content = rt;
    issue      = iss;
  endtask

  task automatic wait_idle(input string test);
    int cycles;
    cycles = 0;
    while (busy && cycles < MAX_WAIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (busy)
    begin
      $display("Timeout in %s: busy never fell within %0d cycles", test, MAX_WAIT);
      $display("Checks failed");
      $fatal(1, "Timeout waiting for busy to fall");
    end
  endtask

  initial
  begin
    logic [31:0] kind;
    logic [31:0] exp_hi;
    logic [31:0] exp_lo;
    logic [31:0] name_idx;
    string       test;
    clk        = 1'b0;
    arst_n     = 1'b0;
    instr      = '0;
    rs_content = '0;
    rt_content = '0;
    issue      = 1'b0;
    names = '{"reset", "addu", "subu", "logic", "shift", "shift_var", "slt", "addiu",
              "logic_imm", "lui", "slti", "ldst_addr", "beq_bne", "blez_bgtz", "regimm",
              "mult", "div", "divu_zero", "busy_ignore"};
    $readmemh("mips_execute_golden.hex", golden, 0, COLS * NUM_VECS - 1);
    if (^vec_field(NUM_VECS - 1, COLS - 1) === 1'bx)
    begin
      $display("The golden file could not be read completely");
      $display("Checks failed");
      $fatal(1, "Golden file unreadable");
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_value("reset busy", 32'h0, {31'b0, busy});
    check_value("reset hi", 32'h0, hi);
    check_value("reset lo", 32'h0, lo);

    for (int v = 0; v < NUM_VECS; v++)
    begin
      kind     = vec_field(v, 0);
      exp_hi   = vec_field(v, 6);
      exp_lo   = vec_field(v, 7);
      name_idx = vec_field(v, 8);
      test     = $sformatf("%s[%0d]", names[name_idx[4:0]], v);
      if (kind == 32'd0)
      begin
        apply(vec_field(v, 1), vec_field(v, 2), vec_field(v, 3), 1'b0);
        @(posedge clk); // Combinational result settled since the falling edge
        check_value({test, " result"}, vec_field(v, 4), alu_result);
        check_value({test, " branch"}, vec_field(v, 5), {31'b0, branch_taken});
      end
      else if (kind == 32'd1 || kind == 32'd2)
      begin
        apply(vec_field(v, 1), vec_field(v, 2), vec_field(v, 3), 1'b1);
        if (kind == 32'd2)
        begin
          apply(vec_field(v, 1), ~vec_field(v, 2), ~vec_field(v, 3), 1'b1); // Must be dropped
        end
        apply(32'h0, 32'h0, 32'h0, 1'b0);
        check_value({test, " busy"}, 32'h1, {31'b0, busy});
        wait_idle(test);
        check_value({test, " hi"}, exp_hi, hi);
        check_value({test, " lo"}, exp_lo, lo);
        apply(MFHI_INSTR, 32'h0, 32'h0, 1'b0);
        @(posedge clk);
        check_value({test, " mfhi"}, exp_hi, alu_result);
        apply(MFLO_INSTR, 32'h0, 32'h0, 1'b0);
        @(posedge clk);
        check_value({test, " mflo"}, exp_lo, alu_result);
      end
      else
      begin
        $display("Golden line %0d has an unknown vector kind %h", v, kind);
        $display("Checks failed");
        $fatal(1, "Bad golden vector");
      end
    end

    $display("All checks passed");
    $finish;
  end

endmodule
